// File: source/dll_pkg.sv
//----------------------------------------------------------------------
// dll code path package
// delay code layout, vote filter and lock constants, and the
// encoding of the code controller state machine
//----------------------------------------------------------------------

package dll_pkg;

  //--------------------------------------------------------------------
  // delay code layout
  //--------------------------------------------------------------------
  localparam int code_w   = 10;                 // full binary delay code
  localparam int coarse_w = 7;                  // upper bits, coarse taps
  localparam int fine_w   = 3;                  // lower bits, fine interpolator

  // top code value, saturation point for up steps
  localparam int code_max = (1 << code_w) - 1;

  //--------------------------------------------------------------------
  // vote filter
  //--------------------------------------------------------------------
  localparam int filter_thresh = 4;             // net votes per code step
  localparam int filter_cnt_w  = 4;             // signed accumulator width

  //--------------------------------------------------------------------
  // lock detection
  //--------------------------------------------------------------------
  // direction reversals before the loop counts as locked
  localparam int lock_reversals = 4;

  // controller states
  typedef enum logic [1:0] {
    dll_idle   = 2'd0,                          // one cycle out of reset
    dll_search = 2'd1,                          // stepping, counting reversals
    dll_locked = 2'd2                           // dithering around the edge
  } dll_state_e;

endpackage

// File: source/dll_phase_filter.sv
//----------------------------------------------------------------------
// dll phase vote filter
// integrates early/late reports from the phase detector and issues a
// single one-cycle code step each time the net vote hits threshold
//----------------------------------------------------------------------

`timescale 1ns/1ps

module dll_phase_filter (
  input  logic clk,
  input  logic reset_n,
  input  logic pd_early,        // sampled clock early, code must go up
  input  logic pd_late,         // sampled clock late, code must go down
  input  logic code_ovrd_en,    // override holds the filter clear
  output logic step_up,
  output logic step_dn
);

  import dll_pkg::*;

  logic signed [filter_cnt_w-1:0] vote_acc;     // net early minus late
  logic signed [filter_cnt_w-1:0] acc_next;
  logic                           vote_up;
  logic                           vote_dn;
  logic                           hit_up;
  logic                           hit_dn;

  // both or neither high is no information
  assign vote_up = pd_early & ~pd_late;
  assign vote_dn = pd_late & ~pd_early;

  always_comb begin
    acc_next = vote_acc;
    if (vote_up) begin
      acc_next = vote_acc + filter_cnt_w'(1);
    end else if (vote_dn) begin
      acc_next = vote_acc - filter_cnt_w'(1);
    end
  end

  // threshold detect on the updated count
  assign hit_up = (acc_next == filter_cnt_w'(filter_thresh));
  assign hit_dn = (acc_next == -filter_cnt_w'(filter_thresh));

  //--------------------------------------------------------------------
  // accumulator and step pulses
  //--------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      vote_acc <= '0;
      step_up  <= 1'b0;
      step_dn  <= 1'b0;
    end else if (code_ovrd_en) begin
      vote_acc <= '0;                           // stale votes dropped
      step_up  <= 1'b0;
      step_dn  <= 1'b0;
    end else begin
      step_up  <= hit_up;
      step_dn  <= hit_dn;
      vote_acc <= (hit_up || hit_dn) ? '0 : acc_next; // restart after a step
    end
  end

  // controller applies at most one direction per cycle
  a_step_excl: assert property (@(posedge clk) disable iff (!reset_n)
    !(step_up && step_dn));

endmodule

// File: source/dll_code_ctrl.sv
//----------------------------------------------------------------------
// dll delay code controller
// keeps the saturating 10-bit binary delay code, applies filter steps
// and register overrides, and decides lock from step reversals
//----------------------------------------------------------------------

`timescale 1ns/1ps

module dll_code_ctrl (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       step_up,      // one-cycle pulse from filter
  input  logic                       step_dn,      // one-cycle pulse from filter
  input  logic                       code_ovrd_en, // override level
  input  logic [dll_pkg::code_w-1:0] code_ovrd,    // override value
  output logic [dll_pkg::code_w-1:0] dll_code,     // reference delay code
  output logic                       dll_lock
);

  import dll_pkg::*;

  dll_state_e                             state;
  logic [$clog2(lock_reversals + 1)-1:0]  rev_cnt;    // reversals seen in search
  logic                                   last_up;    // direction of previous step
  logic                                   dir_valid;  // last_up holds a real step
  logic                                   step_any;
  logic                                   reversal;
  logic                                   at_max;
  logic                                   at_min;

  assign step_any = step_up | step_dn;

  // a reversal needs a previous step to compare against
  assign reversal = step_any & dir_valid & (last_up != step_up);

  assign at_max = (dll_code == code_w'(code_max));
  assign at_min = (dll_code == '0);

  //--------------------------------------------------------------------
  // code register
  //--------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      dll_code <= '0;
    end else if (code_ovrd_en) begin
      dll_code <= code_ovrd;                    // override wins over steps
    end else if (step_up && !at_max) begin
      dll_code <= dll_code + 1'b1;
    end else if (step_dn && !at_min) begin
      dll_code <= dll_code - 1'b1;
    end
    // steps into either end are dropped, code stays saturated
  end

  //--------------------------------------------------------------------
  // lock state machine
  //--------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= dll_idle;
      rev_cnt   <= '0;
      last_up   <= 1'b0;
      dir_valid <= 1'b0;
      dll_lock  <= 1'b0;
    end else if (code_ovrd_en) begin
      // new code loaded, lock history no longer meaningful
      state     <= dll_search;
      rev_cnt   <= '0;
      last_up   <= 1'b0;
      dir_valid <= 1'b0;
      dll_lock  <= 1'b0;
    end else begin
      case (state)
        dll_idle: begin
          state <= dll_search;                  // leave idle right after reset
        end
        dll_search: begin
          if (step_any) begin
            last_up   <= step_up;               // saturated steps still count
            dir_valid <= 1'b1;
          end
          if (reversal) begin
            rev_cnt <= rev_cnt + 1'b1;
            if (int'(rev_cnt) == lock_reversals - 1) begin
              state    <= dll_locked;           // lock with this code update
              dll_lock <= 1'b1;
            end
          end
        end
        dll_locked: begin
          dll_lock <= 1'b1;                     // keep tracking, stay locked
        end
        default: begin
          state    <= dll_idle;
          dll_lock <= 1'b0;
        end
      endcase
    end
  end

  //--------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------
  // no step and no override means the delay chain sees a steady code
  a_code_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (!step_any && !code_ovrd_en) |=> $stable(dll_code));

  // lock flag is a registered copy of the state, never out of step
  a_lock_state: assert property (@(posedge clk) disable iff (!reset_n)
    dll_lock == (state == dll_locked));

  // a step moves the code by one tap or not at all
  a_step_size: assert property (@(posedge clk) disable iff (!reset_n)
    (step_any && !code_ovrd_en) |=>
      ($stable(dll_code) ||
       (dll_code == $past(dll_code) + 1'b1) ||
       (dll_code == $past(dll_code) - 1'b1)));

endmodule

// File: source/quadph_code_gen.sv
//----------------------------------------------------------------------
// quadrature phase code generator
// derives a quarter-delay code from the dll reference code and
// registers either that code or the reference code for the chain
//----------------------------------------------------------------------

`timescale 1ns/1ps

module quadph_code_gen (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic [dll_pkg::code_w-1:0] ref_code,   // reference code from controller
  input  logic                       quad_sel,   // 1 quarter code, 0 reference
  output logic [dll_pkg::code_w-1:0] quad_code   // code for the delay chain
);

  import dll_pkg::*;

  logic [coarse_w-1:0] ref_coarse;
  logic [fine_w-1:0]   ref_fine;
  logic [coarse_w-1:0] quad_coarse;
  logic [fine_w-1:0]   quad_fine;
  logic                fine_round;

  assign ref_coarse = ref_code[code_w-1:fine_w];
  assign ref_fine   = ref_code[fine_w-1:0];

  // coarse divided by four
  assign quad_coarse = ref_coarse >> 2;

  // round up when the dropped fine bits are half a step or more
  assign fine_round = (ref_fine[1:0] >= 2'd2);

  // coarse remainder goes into the fine field as two fine taps each,
  // plus the fine field divided by four, wraps at 8 by design
  assign quad_fine = {ref_coarse[1:0], 1'b0}
                   + fine_w'(ref_fine[fine_w-1])
                   + fine_w'(fine_round);

  //--------------------------------------------------------------------
  // output register
  //--------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      quad_code <= '0;
    end else if (quad_sel) begin
      quad_code <= {quad_coarse, quad_fine};
    end else begin
      quad_code <= ref_code;                    // pass through
    end
  end

  // quarter code coarse field cannot exceed a quarter of full range
  a_quad_range: assert property (@(posedge clk) disable iff (!reset_n)
    quad_sel |=>
      (quad_code[code_w-1:fine_w] <= coarse_w'(code_max >> (fine_w + 2))));

endmodule

// File: source/dll_code_top.sv
//----------------------------------------------------------------------
// dll delay code path top
// phase vote filter, code controller and quadrature code generator
// in a straight chain from detector levels to delay chain code
//----------------------------------------------------------------------

`timescale 1ns/1ps

module dll_code_top (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       pd_early,      // phase detector early level
  input  logic                       pd_late,       // phase detector late level
  input  logic                       code_ovrd_en,  // override level
  input  logic [dll_pkg::code_w-1:0] code_ovrd,     // override value
  input  logic                       quad_sel,      // quarter code select
  output logic [dll_pkg::code_w-1:0] dll_code,      // reference code
  output logic [dll_pkg::code_w-1:0] quad_code,     // delay chain code
  output logic                       dll_lock
);

  // filter to controller step pulses
  logic step_up;
  logic step_dn;

  //--------------------------------------------------------------------
  // vote filter, one cycle from completing vote to step
  //--------------------------------------------------------------------
  dll_phase_filter u_filter (
    .clk          (clk),
    .reset_n      (reset_n),
    .pd_early     (pd_early),
    .pd_late      (pd_late),
    .code_ovrd_en (code_ovrd_en),
    .step_up      (step_up),
    .step_dn      (step_dn)
  );

  // code controller, one cycle from step or override to code
  dll_code_ctrl u_ctrl (
    .clk          (clk),
    .reset_n      (reset_n),
    .step_up      (step_up),
    .step_dn      (step_dn),
    .code_ovrd_en (code_ovrd_en),
    .code_ovrd    (code_ovrd),
    .dll_code     (dll_code),
    .dll_lock     (dll_lock)
  );

  // quadrature generator, one more cycle to the chain code
  quadph_code_gen u_quad (
    .clk          (clk),
    .reset_n      (reset_n),
    .ref_code     (dll_code),
    .quad_sel     (quad_sel),
    .quad_code    (quad_code)
  );

endmodule

// File: dv/dll_code_tb.sv
//----------------------------------------------------------------------
// dll code path testbench
// replays vector file operations on the dll code top and checks
// dll_code, quad_code and dll_lock after each one
//----------------------------------------------------------------------

`timescale 1ns/1ps

module dll_code_tb;

  localparam int settle_cycles = 3;             // filter, controller, quad regs
  localparam int margin_cycles = 100;

  logic       clk;
  logic       reset_n;
  logic       pd_early;
  logic       pd_late;
  logic       code_ovrd_en;
  logic [9:0] code_ovrd;
  logic       quad_sel;
  logic [9:0] dll_code;
  logic [9:0] quad_code;
  logic       dll_lock;

  // vector table, one entry per operation line
  byte        op_q[$];
  int         arg_q[$];
  logic [9:0] exp_dll_q[$];
  logic [9:0] exp_quad_q[$];
  logic       exp_lock_q[$];

  int cycle_limit = 0;                          // zero until vectors loaded
  int cycle_cnt   = 0;
  int vec_idx     = 0;

  dll_code_top dut (
    .clk          (clk),
    .reset_n      (reset_n),
    .pd_early     (pd_early),
    .pd_late      (pd_late),
    .code_ovrd_en (code_ovrd_en),
    .code_ovrd    (code_ovrd),
    .quad_sel     (quad_sel),
    .dll_code     (dll_code),
    .quad_code    (quad_code),
    .dll_lock     (dll_lock)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                      // 10 ns period
  end

  //--------------------------------------------------------------------
  // helpers
  //--------------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("ERROR: %s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h (vector %0d)",
               name, actual, expected, vec_idx);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // cycles an operation takes, negative for an unknown letter
  function automatic int op_length(input byte op, input int arg);
    case (op)
      "O":     return 2;                        // enable cycle plus release
      "S":     return 1;
      "E", "L", "B": return arg + 1;            // votes plus return to idle
      "W":     return arg;
      default: return -1;
    endcase
  endfunction

  task automatic load_vectors();
    int    fd;
    int    n;
    int    len;
    int    arg;
    int    exp_d;
    int    exp_q;
    int    exp_l;
    int    total;
    bit    done;
    string tok;
    string rest;
    fd    = $fopen("dv/dll_code_vectors.txt", "r");
    total = 0;
    done  = 1'b0;
    if (fd == 0) begin
      abort_run("could not open the vector file dv/dll_code_vectors.txt");
    end else begin
      while (!done) begin
        n = $fscanf(fd, "%s", tok);
        if (n != 1) begin
          done = 1'b1;                          // end of file
        end else if (tok.getc(0) == "#") begin
          n = $fgets(rest, fd);                 // skip comment line
        end else begin
          n   = $fscanf(fd, "%h %h %h %h", arg, exp_d, exp_q, exp_l);
          len = op_length(tok.getc(0), arg);
          if (n != 4 || len < 0) begin
            abort_run($sformatf("bad vector line starting with '%s'", tok));
          end else begin
            op_q.push_back(tok.getc(0));
            arg_q.push_back(arg);
            exp_dll_q.push_back(exp_d[9:0]);
            exp_quad_q.push_back(exp_q[9:0]);
            exp_lock_q.push_back(exp_l[0]);
            total += len + settle_cycles;
          end
        end
      end
      $fclose(fd);
      if (op_q.size() == 0) begin
        abort_run("the vector file holds no operations");
      end else begin
        cycle_limit = total + margin_cycles;
      end
    end
  endtask

  task automatic drive_votes(input logic early, input logic late, input int n);
    repeat (n) begin
      @(posedge clk);
      pd_early <= early;
      pd_late  <= late;
    end
    @(posedge clk);
    pd_early <= 1'b0;                           // back to no information
    pd_late  <= 1'b0;
  endtask

  task automatic run_op(input byte op, input int arg);
    case (op)
      "O": begin
        @(posedge clk);
        code_ovrd_en <= 1'b1;
        code_ovrd    <= arg[9:0];
        @(posedge clk);
        code_ovrd_en <= 1'b0;                   // single cycle override
      end
      "S": begin
        @(posedge clk);
        quad_sel <= arg[0];
      end
      "E": drive_votes(1'b1, 1'b0, arg);
      "L": drive_votes(1'b0, 1'b1, arg);
      "B": drive_votes(1'b1, 1'b1, arg);
      "W": repeat (arg) @(posedge clk);
      default: abort_run("unknown operation letter in vector table");
    endcase
  endtask

  //--------------------------------------------------------------------
  // main sequence
  //--------------------------------------------------------------------
  initial begin
    void'($urandom(32'he85e_ab82));             // one seed for the run
    reset_n      = 1'b0;
    pd_early     = 1'b0;
    pd_late      = 1'b0;
    code_ovrd_en = 1'b0;
    code_ovrd    = '0;
    quad_sel     = 1'b0;
    load_vectors();
    repeat (3) @(posedge clk);
    reset_n <= 1'b1;
    for (int i = 0; i < op_q.size(); i++) begin
      vec_idx = i;
      repeat ($urandom % 2) @(posedge clk);     // idle gap, no votes
      run_op(op_q[i], arg_q[i]);
      repeat (settle_cycles) @(posedge clk);
      @(negedge clk);                           // outputs stable here
      check_value("dll_code", dll_code, exp_dll_q[i]);
      check_value("quad_code", quad_code, exp_quad_q[i]);
      check_value("dll_lock", dll_lock, exp_lock_q[i]);
    end
    $display("Simulation completed successfully");
    $finish;
  end

  // watchdog, limit comes from the vector table length
  initial begin
    wait (cycle_limit != 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("ERROR: timeout, run did not finish within %0d cycles", cycle_limit);
    $display("Simulation failed");
    $fatal(1);
  end

endmodule

// File: build.f
source/dll_pkg.sv
source/dll_phase_filter.sv
source/dll_code_ctrl.sv
source/quadph_code_gen.sv
source/dll_code_top.sv
dv/dll_code_tb.sv

// File: Makefile
# Verilator build and run for the dll code path testbench
# any variable can be overridden on the command line, e.g. make sim TOP=...

VERILATOR ?= verilator
TOP       ?= dll_code_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

# build, run, then look for the pass message in the run output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/dll_code_vectors.txt
# op arg exp_dll_code exp_quad_code exp_dll_lock, all fields hex
# ops: O override value, S quad_sel, E/L/B vote cycles early/late/both, W wait cycles
# reset values
W 5 000 000 0
S 0 000 000 0
# overrides, quad code as copy then as quarter code
O 3FF 3FF 3FF 0
S 1 3FF 0F8 0
O 1FF 1FF 078 0
O 155 155 055 0
S 0 155 155 0
O 2A6 2A6 2A6 0
S 1 2A6 0AA 0
O 0CB 0CB 033 0
S 0 0CB 0CB 0
# vote filter, single steps and cancelling votes
O 100 100 100 0
E 4 101 101 0
L 4 100 100 0
E 1 100 100 0
L 1 100 100 0
E 1 100 100 0
L 1 100 100 0
B 8 100 100 0
E 3 100 100 0
B 4 100 100 0
E 1 101 101 0
L 2 101 101 0
E 1 101 101 0
L 3 100 100 0
# saturation at both ends
O 3FF 3FF 3FF 0
E 4 3FF 3FF 0
E 4 3FF 3FF 0
L 4 3FE 3FE 0
E 4 3FF 3FF 0
O 000 000 000 0
L 4 000 000 0
L 4 000 000 0
E 4 001 001 0
L 4 000 000 0
L 4 000 000 0
# lock after four reversals, kept while tracking, dropped by override
S 1 000 000 0
O 1FD 1FD 07F 0
E 4 1FE 078 0
L 4 1FD 07F 0
E 4 1FE 078 0
L 4 1FD 07F 0
E 4 1FE 078 1
E 4 1FF 078 1
L 4 1FE 078 1
B 6 1FE 078 1
W A 1FE 078 1
O 2A6 2A6 0AA 0
E 4 2A7 0AA 0
L 4 2A6 0AA 0
S 0 2A6 2A6 0
W 4 2A6 2A6 0
